/* rtl/core_pkg.sv */
// mips pipeline core definitions
package core_pkg;

   //////////////////////////////
   // widths and reset values
   //////////////////////////////
   localparam int WORD_W = 32;
   localparam int REG_AW = 5;
   localparam logic [WORD_W-1:0] PC_RESET = '0;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [REG_AW-1:0] regbits_t;

   //////////////////////////////
   // instruction encodings
   //////////////////////////////
   typedef enum logic [5:0] {
      RTYPE = 6'h00,
      BEQ   = 6'h04,
      ADDIU = 6'h09,
      ORI   = 6'h0d,
      LW    = 6'h23,
      SW    = 6'h2b,
      HALT  = 6'h3f
   } opcode_t;

   typedef enum logic [5:0] {
      ADDU = 6'h21,
      SUBU = 6'h23,
      AND  = 6'h24,
      OR   = 6'h25,
      SLT  = 6'h2a
   } funct_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_SLT
   } aluop_t;

   // operand source in execute
   typedef enum logic [1:0] {
      FWD_NONE,
      FWD_MEM,
      FWD_WB
   } fwd_sel_t;

   //////////////////////////////
   // stage payloads
   //////////////////////////////
   typedef struct packed {
      aluop_t aluop;
      logic   alu_src;  // immediate as operand b
      logic   reg_wen;
      logic   mem_ren;
      logic   mem_wen;
      logic   branch;   // beq
      logic   halt;
   } ctrl_t;

   typedef struct packed {
      ctrl_t    ctrl;
      word_t    npc;
      word_t    rdat1;
      word_t    rdat2;
      word_t    imm;
      regbits_t rs;
      regbits_t rt;
      regbits_t dst;
   } idex_t;

   typedef struct packed {
      ctrl_t    ctrl;
      word_t    alu_out;
      word_t    store;
      regbits_t dst;
   } exmem_t;

   typedef struct packed {
      logic     reg_wen;
      logic     mem2reg;
      logic     halt;
      word_t    alu_out;
      word_t    load;
      regbits_t dst;
   } memwb_t;

   //////////////////////////////
   // memory ports
   //////////////////////////////
   typedef struct packed {
      logic  ren;
      word_t addr;
   } imem_req_t;

   typedef struct packed {
      logic  ihit;
      word_t load;
   } imem_rsp_t;

   typedef struct packed {
      logic  ren;
      logic  wen;
      word_t addr;
      word_t store;
   } dmem_req_t;

   typedef struct packed {
      logic  dhit;
      word_t load;
   } dmem_rsp_t;

endpackage

/* rtl/reg_file.sv */
// register file
module reg_file (
   input  logic               CLK,
   input  logic               nRST,
   input  core_pkg::regbits_t rsel1_i,
   input  core_pkg::regbits_t rsel2_i,
   input  core_pkg::regbits_t wsel_i,
   input  logic               wen_i,
   input  core_pkg::word_t    wdat_i,
   output core_pkg::word_t    rdat1_o,
   output core_pkg::word_t    rdat2_o
);
   import core_pkg::*;

   word_t regs [2**REG_AW];
   logic  wr_ok;

   assign wr_ok = wen_i && (wsel_i != '0);  // $zero never written

   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         regs <= '{default: '0};
      end else if (wr_ok) begin
         regs[wsel_i] <= wdat_i;
      end
   end

   // write-through, decode sees the writeback value in the same cycle
   assign rdat1_o = (wr_ok && wsel_i == rsel1_i) ? wdat_i : regs[rsel1_i];
   assign rdat2_o = (wr_ok && wsel_i == rsel2_i) ? wdat_i : regs[rsel2_i];

   // bypass must not leak a write aimed at $zero
   assert property (@(posedge CLK) disable iff (!nRST)
      (rsel1_i == '0) |-> (rdat1_o == '0))
      else $error("register zero read as %h", rdat1_o);

endmodule

/* rtl/fetch_stage.sv */
// instruction fetch stage
module fetch_stage (
   input  logic                CLK,
   input  logic                nRST,
   input  logic                advance_i,
   input  logic                stall_i,
   input  logic                flush_i,
   input  logic                branch_taken_i,
   input  core_pkg::word_t     branch_target_i,
   input  logic                halt_i,
   input  core_pkg::imem_rsp_t imem_rsp_i,
   output core_pkg::imem_req_t imem_req_o,
   output core_pkg::word_t     ifid_instr_o,
   output core_pkg::word_t     ifid_npc_o
);
   import core_pkg::*;

   word_t pc, npc, pc_next;

   assign npc     = pc + 32'd4;
   assign pc_next = branch_taken_i ? branch_target_i : npc; // redirect from execute

   assign imem_req_o.ren  = !halt_i;  // no more fetches once halted
   assign imem_req_o.addr = pc;

   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         pc <= PC_RESET;
      end else if (advance_i && !stall_i) begin
         pc <= pc_next;
      end
   end

   // if/id register
   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         ifid_instr_o <= '0;
         ifid_npc_o   <= '0;
      end else if (advance_i) begin
         if (flush_i) begin
            ifid_instr_o <= '0;   // all zero decodes as a nop
            ifid_npc_o   <= '0;
         end else if (!stall_i) begin
            ifid_instr_o <= imem_rsp_i.load;
            ifid_npc_o   <= npc;
         end
      end
   end

   // branch targets from execute must keep the pc word aligned
   assert property (@(posedge CLK) disable iff (!nRST) pc[1:0] == 2'b00)
      else $error("pc not word aligned: %h", pc);

endmodule

/* rtl/decode_stage.sv */
// instruction decode stage
module decode_stage (
   input  logic               CLK,
   input  logic               nRST,
   input  logic               advance_i,
   input  logic               flush_i,
   input  core_pkg::word_t    ifid_instr_i,
   input  core_pkg::word_t    ifid_npc_i,
   input  logic               wb_wen_i,
   input  core_pkg::regbits_t wb_wsel_i,
   input  core_pkg::word_t    wb_wdat_i,
   output core_pkg::regbits_t rs_o,
   output core_pkg::regbits_t rt_o,
   output core_pkg::idex_t    idex_o
);
   import core_pkg::*;

   opcode_t  op;
   funct_t   fn;
   regbits_t rd;
   ctrl_t    ctrl;
   word_t    rdat1, rdat2, imm_ext;
   idex_t    idex_d;

   //////////////////////////////
   // field split
   //////////////////////////////
   assign op   = opcode_t'(ifid_instr_i[31:26]);
   assign fn   = funct_t'(ifid_instr_i[5:0]);
   assign rs_o = ifid_instr_i[25:21];
   assign rt_o = ifid_instr_i[20:16];
   assign rd   = ifid_instr_i[15:11];

   // ori zero-extends, everything else sign-extends
   assign imm_ext = (op == ORI) ? {16'h0, ifid_instr_i[15:0]}
                                : {{16{ifid_instr_i[15]}}, ifid_instr_i[15:0]};

   reg_file rf_i (
      .CLK     (CLK),
      .nRST    (nRST),
      .rsel1_i (rs_o),
      .rsel2_i (rt_o),
      .wsel_i  (wb_wsel_i),
      .wen_i   (wb_wen_i),
      .wdat_i  (wb_wdat_i),
      .rdat1_o (rdat1),
      .rdat2_o (rdat2)
   );

   //////////////////////////////
   // control decode
   //////////////////////////////
   always_comb begin
      ctrl = '0;  // unknown ops become bubbles
      case (op)
         RTYPE: begin
            ctrl.reg_wen = 1'b1;
            case (fn)
               ADDU:    ctrl.aluop = ALU_ADD;
               SUBU:    ctrl.aluop = ALU_SUB;
               AND:     ctrl.aluop = ALU_AND;
               OR:      ctrl.aluop = ALU_OR;
               SLT:     ctrl.aluop = ALU_SLT;
               default: ctrl.reg_wen = 1'b0;  // sll 0 nop and dropped functs
            endcase
         end
         ADDIU: begin
            ctrl.alu_src = 1'b1;
            ctrl.reg_wen = 1'b1;
         end
         ORI: begin
            ctrl.aluop   = ALU_OR;
            ctrl.alu_src = 1'b1;
            ctrl.reg_wen = 1'b1;
         end
         LW: begin
            ctrl.alu_src = 1'b1;   // base + offset
            ctrl.reg_wen = 1'b1;
            ctrl.mem_ren = 1'b1;
         end
         SW: begin
            ctrl.alu_src = 1'b1;
            ctrl.mem_wen = 1'b1;
         end
         BEQ: begin
            ctrl.aluop  = ALU_SUB;
            ctrl.branch = 1'b1;
         end
         HALT:    ctrl.halt = 1'b1;
         default: ;
      endcase
   end

   always_comb begin
      idex_d.ctrl  = ctrl;
      idex_d.npc   = ifid_npc_i;
      idex_d.rdat1 = rdat1;
      idex_d.rdat2 = rdat2;
      idex_d.imm   = imm_ext;
      idex_d.rs    = rs_o;
      idex_d.rt    = rt_o;
      idex_d.dst   = (op == RTYPE) ? rd : rt_o;  // i-type writes rt
   end

   // id/ex register, flush also covers the load-use bubble
   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         idex_o <= '0;
      end else if (advance_i) begin
         idex_o <= flush_i ? '0 : idex_d;
      end
   end

endmodule

/* rtl/execute_stage.sv */
// execute stage
module execute_stage (
   input  logic               CLK,
   input  logic               nRST,
   input  logic               advance_i,
   input  core_pkg::idex_t    idex_i,
   input  core_pkg::fwd_sel_t fwd_a_i,
   input  core_pkg::fwd_sel_t fwd_b_i,
   input  core_pkg::word_t    mem_fwd_i,
   input  core_pkg::word_t    wb_fwd_i,
   output logic               branch_taken_o,
   output core_pkg::word_t    branch_target_o,
   output core_pkg::exmem_t   exmem_o
);
   import core_pkg::*;

   word_t  op_a, rt_val, op_b, alu_out;
   exmem_t exmem_d;

   //////////////////////////////
   // forwarding muxes
   //////////////////////////////
   always_comb begin
      case (fwd_a_i)
         FWD_MEM: op_a = mem_fwd_i;
         FWD_WB:  op_a = wb_fwd_i;
         default: op_a = idex_i.rdat1;
      endcase
      case (fwd_b_i)
         FWD_MEM: rt_val = mem_fwd_i;
         FWD_WB:  rt_val = wb_fwd_i;
         default: rt_val = idex_i.rdat2;
      endcase
   end

   assign op_b = idex_i.ctrl.alu_src ? idex_i.imm : rt_val;

   // alu
   always_comb begin
      case (idex_i.ctrl.aluop)
         ALU_SUB: alu_out = op_a - op_b;
         ALU_AND: alu_out = op_a & op_b;
         ALU_OR:  alu_out = op_a | op_b;
         ALU_SLT: alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
         default: alu_out = op_a + op_b;
      endcase
   end

   // beq resolves here; halt also squashes the younger pair and refetches npc
   assign branch_taken_o  = (idex_i.ctrl.branch && (op_a == rt_val)) || idex_i.ctrl.halt;
   assign branch_target_o = idex_i.ctrl.halt ? idex_i.npc
                                             : idex_i.npc + {idex_i.imm[29:0], 2'b00};

   always_comb begin
      exmem_d.ctrl    = idex_i.ctrl;
      exmem_d.alu_out = alu_out;
      exmem_d.store   = rt_val;   // forwarded rt for sw
      exmem_d.dst     = idex_i.dst;
   end

   // ex/mem register
   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         exmem_o <= '0;
      end else if (advance_i) begin
         exmem_o <= exmem_d;
      end
   end

endmodule

/* rtl/memory_stage.sv */
// memory access and writeback select
module memory_stage (
   input  logic                CLK,
   input  logic                nRST,
   input  logic                advance_i,
   input  core_pkg::exmem_t    exmem_i,
   input  core_pkg::dmem_rsp_t dmem_rsp_i,
   output core_pkg::dmem_req_t dmem_req_o,
   output logic                dwait_o,
   output core_pkg::memwb_t    memwb_o,
   output logic                wb_wen_o,
   output core_pkg::regbits_t  wb_wsel_o,
   output core_pkg::word_t     wb_wdat_o
);
   import core_pkg::*;

   logic   access, ddone;
   word_t  dload_q, load_val;
   memwb_t memwb_d;

   assign access = exmem_i.ctrl.mem_ren || exmem_i.ctrl.mem_wen;

   // request drops once the hit came, so a store lands only once
   assign dmem_req_o.ren   = exmem_i.ctrl.mem_ren && !ddone;
   assign dmem_req_o.wen   = exmem_i.ctrl.mem_wen && !ddone;
   assign dmem_req_o.addr  = exmem_i.alu_out;
   assign dmem_req_o.store = exmem_i.store;

   assign dwait_o = access && !ddone && !dmem_rsp_i.dhit;

   // hit seen while fetch still waits on ihit
   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         ddone <= 1'b0;
      end else if (advance_i) begin
         ddone <= 1'b0;
      end else if (access && dmem_rsp_i.dhit) begin
         ddone <= 1'b1;
      end
   end

   always_ff @(posedge CLK) begin
      if (dmem_rsp_i.dhit && !ddone) begin
         dload_q <= dmem_rsp_i.load;
      end
   end

   assign load_val = ddone ? dload_q : dmem_rsp_i.load;

   always_comb begin
      memwb_d.reg_wen = exmem_i.ctrl.reg_wen;
      memwb_d.mem2reg = exmem_i.ctrl.mem_ren;
      memwb_d.halt    = exmem_i.ctrl.halt;
      memwb_d.alu_out = exmem_i.alu_out;
      memwb_d.load    = load_val;
      memwb_d.dst     = exmem_i.dst;
   end

   // mem/wb register
   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         memwb_o <= '0;
      end else if (advance_i) begin
         memwb_o <= memwb_d;
      end
   end

   // writeback
   assign wb_wen_o  = memwb_o.reg_wen;
   assign wb_wsel_o = memwb_o.dst;
   assign wb_wdat_o = memwb_o.mem2reg ? memwb_o.load : memwb_o.alu_out;

   // decode never sets both, lw and sw are exclusive ops
   assert property (@(posedge CLK) disable iff (!nRST) !(dmem_req_o.ren && dmem_req_o.wen))
      else $error("dmem read and write in the same cycle");

endmodule

/* rtl/hazard_control.sv */
// hazard, forwarding and halt control
module hazard_control (
   input  logic                CLK,
   input  logic                nRST,
   input  logic                ihit_i,
   input  logic                dwait_i,
   input  core_pkg::regbits_t  id_rs_i,
   input  core_pkg::regbits_t  id_rt_i,
   input  core_pkg::regbits_t  ex_rs_i,
   input  core_pkg::regbits_t  ex_rt_i,
   input  logic                ex_memread_i,
   input  logic                branch_taken_i,
   input  core_pkg::regbits_t  mem_dst_i,
   input  core_pkg::regbits_t  wb_dst_i,
   input  logic                mem_wen_i,
   input  logic                wb_wen_i,
   input  logic                wb_halt_i,
   output logic                advance_o,
   output logic                stall_o,
   output logic                flush_id_o,
   output logic                flush_ex_o,
   output core_pkg::fwd_sel_t  fwd_a_o,
   output core_pkg::fwd_sel_t  fwd_b_o,
   output logic                halt_o
);
   import core_pkg::*;

   logic halt_q;

   //////////////////////////////
   // pipeline step
   //////////////////////////////
   // freeze from the moment halt reaches writeback
   assign advance_o = ihit_i && !dwait_i && !wb_halt_i;

   // load-use when decode reads what the load in execute has not fetched yet
   assign stall_o = ex_memread_i && (ex_rt_i != '0)
                    && (ex_rt_i == id_rs_i || ex_rt_i == id_rt_i);

   assign flush_id_o = branch_taken_i;
   assign flush_ex_o = branch_taken_i || stall_o;  // bubble into id/ex

   //////////////////////////////
   // forwarding
   //////////////////////////////
   function automatic fwd_sel_t fwd_pick(input regbits_t src);
      fwd_sel_t sel;
      sel = FWD_NONE;
      if (mem_wen_i && mem_dst_i != '0 && mem_dst_i == src) begin
         sel = FWD_MEM;   // youngest result wins
      end else if (wb_wen_i && wb_dst_i != '0 && wb_dst_i == src) begin
         sel = FWD_WB;
      end
      return sel;
   endfunction

   always_comb begin
      fwd_a_o = fwd_pick(ex_rs_i);
      fwd_b_o = fwd_pick(ex_rt_i);
   end

   // halt latch stays set until reset
   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         halt_q <= 1'b0;
      end else if (wb_halt_i) begin
         halt_q <= 1'b1;
      end
   end

   assign halt_o = halt_q;

   // once halted the core stays halted and frozen
   assert property (@(posedge CLK) disable iff (!nRST) halt_o |=> halt_o && !advance_o)
      else $error("pipeline moved after halt");

endmodule

/* rtl/mips_pipe_top.sv */
// pipelined mips core top
module mips_pipe_top (
   input  logic                CLK,
   input  logic                nRST,
   input  core_pkg::imem_rsp_t imem_rsp_i,
   input  core_pkg::dmem_rsp_t dmem_rsp_i,
   output core_pkg::imem_req_t imem_req_o,
   output core_pkg::dmem_req_t dmem_req_o,
   output logic                halt_o
);
   import core_pkg::*;

   logic     advance, stall, flush_id, flush_ex, branch_taken, dwait, wb_wen;
   fwd_sel_t fwd_a, fwd_b;
   word_t    ifid_instr, ifid_npc, branch_target, wb_wdat;
   regbits_t id_rs, id_rt, wb_wsel;
   idex_t    idex;
   exmem_t   exmem;
   memwb_t   memwb;

   fetch_stage fetch_i (
      .CLK             (CLK),
      .nRST            (nRST),
      .advance_i       (advance),
      .stall_i         (stall),
      .flush_i         (flush_id),
      .branch_taken_i  (branch_taken),
      .branch_target_i (branch_target),
      .halt_i          (halt_o),
      .imem_rsp_i      (imem_rsp_i),
      .imem_req_o      (imem_req_o),
      .ifid_instr_o    (ifid_instr),
      .ifid_npc_o      (ifid_npc)
   );

   decode_stage decode_i (
      .CLK          (CLK),
      .nRST         (nRST),
      .advance_i    (advance),
      .flush_i      (flush_ex),
      .ifid_instr_i (ifid_instr),
      .ifid_npc_i   (ifid_npc),
      .wb_wen_i     (wb_wen),
      .wb_wsel_i    (wb_wsel),
      .wb_wdat_i    (wb_wdat),
      .rs_o         (id_rs),
      .rt_o         (id_rt),
      .idex_o       (idex)
   );

   execute_stage execute_i (
      .CLK             (CLK),
      .nRST            (nRST),
      .advance_i       (advance),
      .idex_i          (idex),
      .fwd_a_i         (fwd_a),
      .fwd_b_i         (fwd_b),
      .mem_fwd_i       (exmem.alu_out),
      .wb_fwd_i        (wb_wdat),
      .branch_taken_o  (branch_taken),
      .branch_target_o (branch_target),
      .exmem_o         (exmem)
   );

   memory_stage memory_i (
      .CLK        (CLK),
      .nRST       (nRST),
      .advance_i  (advance),
      .exmem_i    (exmem),
      .dmem_rsp_i (dmem_rsp_i),
      .dmem_req_o (dmem_req_o),
      .dwait_o    (dwait),
      .memwb_o    (memwb),
      .wb_wen_o   (wb_wen),
      .wb_wsel_o  (wb_wsel),
      .wb_wdat_o  (wb_wdat)
   );

   hazard_control hazard_i (
      .CLK            (CLK),
      .nRST           (nRST),
      .ihit_i         (imem_rsp_i.ihit),
      .dwait_i        (dwait),
      .id_rs_i        (id_rs),
      .id_rt_i        (id_rt),
      .ex_rs_i        (idex.rs),
      .ex_rt_i        (idex.rt),
      .ex_memread_i   (idex.ctrl.mem_ren),
      .branch_taken_i (branch_taken),
      .mem_dst_i      (exmem.dst),
      .wb_dst_i       (memwb.dst),
      .mem_wen_i      (exmem.ctrl.reg_wen),
      .wb_wen_i       (wb_wen),
      .wb_halt_i      (memwb.halt),
      .advance_o      (advance),
      .stall_o        (stall),
      .flush_id_o     (flush_id),
      .flush_ex_o     (flush_ex),
      .fwd_a_o        (fwd_a),
      .fwd_b_o        (fwd_b),
      .halt_o         (halt_o)
   );

endmodule

/* sim/tb_mem_model.sv */
// instruction and data memory model
module tb_mem_model #(
   parameter int WORDS = 256
) (
   input  logic                CLK,
   input  logic                nRST,
   input  logic                rand_en_i,   // 0 forces zero wait cycles
   input  core_pkg::imem_req_t imem_req_i,
   input  core_pkg::dmem_req_t dmem_req_i,
   output core_pkg::imem_rsp_t imem_rsp_o = '0,
   output core_pkg::dmem_rsp_t dmem_rsp_o = '0
);
   import core_pkg::*;

   localparam int AW = $clog2(WORDS);

   word_t  imem [WORDS];
   word_t  dmem [WORDS];
   integer seed  = 32'h50c48dc4;
   int     iwait = -1;   // cycles left before the hit, -1 when idle
   int     dwait = -1;

   // 0 to 3 wait cycles per access
   function automatic int draw_wait();
      if (!rand_en_i) begin
         return 0;
      end
      return $random(seed) & 3;
   endfunction

   always @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         imem_rsp_o <= '0;
         dmem_rsp_o <= '0;
         iwait = -1;
         dwait = -1;
      end else begin
         //////////////////////////////
         // instruction port
         //////////////////////////////
         if (imem_rsp_o.ihit || !imem_req_i.ren) begin
            imem_rsp_o.ihit <= 1'b0;   // hit is a one-cycle pulse
            iwait = -1;
         end else begin
            if (iwait < 0) begin
               iwait = draw_wait();   // new request seen
            end
            if (iwait == 0) begin
               imem_rsp_o.ihit <= 1'b1;
               imem_rsp_o.load <= imem[imem_req_i.addr[2 +: AW]];
            end
            iwait = iwait - 1;   // back to idle on the hit
         end
         //////////////////////////////
         // data port
         //////////////////////////////
         if (dmem_rsp_o.dhit || !(dmem_req_i.ren || dmem_req_i.wen)) begin
            dmem_rsp_o.dhit <= 1'b0;
            dwait = -1;
         end else begin
            if (dwait < 0) begin
               dwait = draw_wait();
            end
            if (dwait == 0) begin
               dmem_rsp_o.dhit <= 1'b1;
               dmem_rsp_o.load <= dmem[dmem_req_i.addr[2 +: AW]];
               if (dmem_req_i.wen) begin
                  dmem[dmem_req_i.addr[2 +: AW]] <= dmem_req_i.store;   // once, on the hit
               end
            end
            dwait = dwait - 1;
         end
      end
   end

endmodule

/* sim/tb_mips_pipe.sv */
// pipelined mips core testbench
module tb_mips_pipe;
   import core_pkg::*;

   localparam int N_ROWS    = 5;
   localparam int MAX_INSTR = 20;
   localparam int MAX_ST    = 8;
   localparam int MAX_INIT  = 4;
   localparam int MEM_WORDS = 256;

   logic      CLK     = 1'b0;
   logic      nRST    = 1'b0;
   logic      rand_en = 1'b0;
   imem_req_t imem_req;
   imem_rsp_t imem_rsp;
   dmem_req_t dmem_req;
   dmem_rsp_t dmem_rsp;
   logic      halt;

   //////////////////////////////
   // test table, one row per run
   //////////////////////////////
   word_t prog     [N_ROWS][MAX_INSTR];
   word_t init_adr [N_ROWS][MAX_INIT];   // data words preset before the run
   word_t init_val [N_ROWS][MAX_INIT];
   word_t exp_adr  [N_ROWS][MAX_ST];     // stores in program order
   word_t exp_dat  [N_ROWS][MAX_ST];
   int    n_prog   [N_ROWS];
   int    n_init   [N_ROWS];
   int    n_exp    [N_ROWS];
   logic  rand_row [N_ROWS];
   string row_name [N_ROWS];

   int cur, st_idx, errors, passed, cycles, cycle_limit;

   always #4 CLK = ~CLK;

   mips_pipe_top mips_pipe_top_i (
      .CLK        (CLK),
      .nRST       (nRST),
      .imem_rsp_i (imem_rsp),
      .dmem_rsp_i (dmem_rsp),
      .imem_req_o (imem_req),
      .dmem_req_o (dmem_req),
      .halt_o     (halt)
   );

   tb_mem_model #(.WORDS(MEM_WORDS)) mem_model_i (
      .CLK        (CLK),
      .nRST       (nRST),
      .rand_en_i  (rand_en),
      .imem_req_i (imem_req),
      .dmem_req_i (dmem_req),
      .imem_rsp_o (imem_rsp),
      .dmem_rsp_o (dmem_rsp)
   );

   // instruction encoders
   function automatic word_t rtype(input funct_t fn, input int rd, input int rs, input int rt);
      return {RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
   endfunction

   function automatic word_t itype(input opcode_t op, input int rt, input int rs, input int imm);
      return {op, 5'(rs), 5'(rt), 16'(imm)};
   endfunction

   task automatic emit(input int r, input word_t w);
      prog[r][n_prog[r]] = w;
      n_prog[r]++;
   endtask

   task automatic preset(input int r, input word_t a, input word_t d);
      init_adr[r][n_init[r]] = a;
      init_val[r][n_init[r]] = d;
      n_init[r]++;
   endtask

   task automatic expect_store(input int r, input word_t a, input word_t d);
      exp_adr[r][n_exp[r]] = a;
      exp_dat[r][n_exp[r]] = d;
      n_exp[r]++;
   endtask

   // dependent alu chain, mem and wb forwarding
   task automatic alu_program(input int r, input logic rnd, input string name);
      rand_row[r] = rnd;
      row_name[r] = name;
      emit(r, itype(ADDIU, 1, 0, 5));
      emit(r, itype(ADDIU, 2, 1, -3));     // $1 from mem
      emit(r, rtype(ADDU, 3, 1, 2));       // $1 from wb, $2 from mem
      emit(r, itype(SW, 3, 0, 0));         // store data forwarded
      emit(r, rtype(SUBU, 4, 3, 1));
      emit(r, rtype(AND, 5, 4, 3));
      emit(r, rtype(OR, 6, 5, 1));
      emit(r, rtype(SLT, 7, 2, 6));
      emit(r, itype(ORI, 8, 7, 'h8000));   // zero extended
      emit(r, itype(ADDIU, 10, 0, -1));
      emit(r, rtype(SLT, 9, 10, 1));       // signed compare
      emit(r, itype(SW, 4, 0, 4));
      emit(r, itype(SW, 5, 0, 8));
      emit(r, itype(SW, 6, 0, 12));
      emit(r, itype(SW, 8, 0, 16));
      emit(r, itype(SW, 9, 0, 20));
      emit(r, {HALT, 26'd0});
      expect_store(r, 0, 7);
      expect_store(r, 4, 2);
      expect_store(r, 8, 2);
      expect_store(r, 12, 7);
      expect_store(r, 16, 'h8001);
      expect_store(r, 20, 1);
   endtask

   // load-use bubbles and writes to $zero
   task automatic load_use_program(input int r, input logic rnd, input string name);
      rand_row[r] = rnd;
      row_name[r] = name;
      emit(r, itype(ADDIU, 1, 0, 'h40));
      emit(r, itype(LW, 2, 1, 0));
      emit(r, rtype(ADDU, 3, 2, 2));       // needs the load at once
      emit(r, itype(SW, 3, 1, 8));
      emit(r, itype(LW, 4, 1, 4));
      emit(r, itype(SW, 4, 1, 12));        // load feeds store data
      emit(r, itype(ADDIU, 0, 0, 'h7f));   // dropped
      emit(r, rtype(ADDU, 5, 0, 4));
      emit(r, itype(SW, 5, 1, 16));
      emit(r, itype(SW, 0, 1, 20));
      emit(r, {HALT, 26'd0});
      preset(r, 'h40, 'h11);
      preset(r, 'h44, 'h100);
      expect_store(r, 'h48, 'h22);
      expect_store(r, 'h4c, 'h100);
      expect_store(r, 'h50, 'h100);
      expect_store(r, 'h54, 0);
   endtask

   // beq taken, not taken, and taken on forwarded operands
   task automatic branch_program(input int r, input logic rnd, input string name);
      rand_row[r] = rnd;
      row_name[r] = name;
      emit(r, itype(ADDIU, 1, 0, 3));
      emit(r, itype(ADDIU, 2, 0, 3));
      emit(r, itype(BEQ, 2, 1, 2));        // taken to word 5
      emit(r, itype(SW, 1, 0, 0));
      emit(r, itype(SW, 2, 0, 4));
      emit(r, itype(BEQ, 0, 1, 1));        // 3 vs 0, falls through
      emit(r, itype(SW, 1, 0, 8));
      emit(r, itype(ADDIU, 3, 1, 4));
      emit(r, itype(ADDIU, 4, 0, 7));
      emit(r, itype(BEQ, 4, 3, 1));        // taken to word 11
      emit(r, itype(SW, 3, 0, 12));
      emit(r, itype(SW, 4, 0, 16));
      emit(r, {HALT, 26'd0});
      expect_store(r, 8, 3);
      expect_store(r, 16, 7);
   endtask

   task automatic fill_memories(input int r);
      for (int i = 0; i < MEM_WORDS; i++) begin
         if (i < n_prog[r]) begin
            mem_model_i.imem[i] = prog[r][i];
         end else begin
            mem_model_i.imem[i] = {HALT, 26'(i)};   // runaway fetch halts
         end
         mem_model_i.dmem[i] = 32'hd5a0_0000 + i;
      end
      for (int i = 0; i < n_init[r]; i++) begin
         mem_model_i.dmem[init_adr[r][i] >> 2] = init_val[r][i];
      end
   endtask

   // store monitor, samples the dmem hit cycle
   always @(posedge CLK) begin
      if (nRST && dmem_rsp.dhit && dmem_req.wen) begin
         if (halt) begin
            $display("test %0d: a store to %h came after halt", cur, dmem_req.addr);
            errors++;
         end else if (st_idx >= n_exp[cur]) begin
            $display("test %0d: extra store of %h to %h", cur, dmem_req.store, dmem_req.addr);
            errors++;
         end else if (dmem_req.addr !== exp_adr[cur][st_idx]
                      || dmem_req.store !== exp_dat[cur][st_idx]) begin
            $display("[ERROR] %0t: test %0d store %0d wrote %h to %h, expected %h to %h",
                     $time, cur, st_idx, dmem_req.store, dmem_req.addr,
                     exp_dat[cur][st_idx], exp_adr[cur][st_idx]);
            errors++;
         end
         st_idx++;
      end
   end

   // watchdog
   initial begin
      wait (cycle_limit > 0);
      while (cycles < cycle_limit) begin
         @(posedge CLK);
         cycles++;
      end
      $display("timeout: run stopped after %0d cycles without finishing", cycles);
      $display("RESULT: FAIL");
      $finish;
   end

   initial begin
      int n;
      int row_errs;
      int lim;
      alu_program(0, 1'b0, "alu chain, no waits");
      alu_program(1, 1'b1, "alu chain, random waits");
      load_use_program(2, 1'b1, "load use and $zero");
      branch_program(3, 1'b1, "beq, random waits");
      branch_program(4, 1'b0, "beq, no waits");
      lim = 0;
      for (int r = 0; r < N_ROWS; r++) begin
         lim += 200 * n_prog[r] + 50;   // reset and post-halt cycles included
      end
      cycle_limit = lim;

      for (int r = 0; r < N_ROWS; r++) begin
         row_errs = errors;
         @(posedge CLK);
         nRST    <= 1'b0;
         rand_en <= rand_row[r];
         cur    = r;
         st_idx = 0;
         fill_memories(r);
         repeat (10) @(posedge CLK);
         // state held by reset
         if (halt !== 1'b0 || dmem_req.ren !== 1'b0 || dmem_req.wen !== 1'b0) begin
            $display("[ERROR] %0t: test %0d reset state halt %b dmem ren %b wen %b",
                     $time, r, halt, dmem_req.ren, dmem_req.wen);
            errors++;
         end
         if (imem_req.ren !== 1'b1 || imem_req.addr !== PC_RESET) begin
            $display("[ERROR] %0t: test %0d first fetch ren %b addr %h, expected 1 %h",
                     $time, r, imem_req.ren, imem_req.addr, PC_RESET);
            errors++;
         end
         nRST <= 1'b1;
         n = 0;
         while (halt !== 1'b1 && n < 200 * n_prog[r]) begin
            @(posedge CLK);
            n++;
         end
         if (halt !== 1'b1) begin
            $display("test %0d: halt_o never came high within %0d cycles", r, n);
            errors++;
         end else begin
            repeat (20) begin
               @(posedge CLK);
               if (halt !== 1'b1 || imem_req.ren !== 1'b0) begin
                  $display("[ERROR] %0t: test %0d after halt halt_o %b imem ren %b",
                           $time, r, halt, imem_req.ren);
                  errors++;
               end
            end
         end
         if (st_idx < n_exp[r]) begin
            $display("test %0d: only %0d of %0d expected stores were seen", r, st_idx, n_exp[r]);
            errors++;
         end
         if (errors == row_errs) begin
            passed++;
         end
         $display("test %0d %s: %s", r, row_name[r], (errors == row_errs) ? "ok" : "failed");
      end

      $display("%0d tests, %0d passed, %0d failed, %0d errors",
               N_ROWS, passed, N_ROWS - passed, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* mips_pipe.f */
rtl/core_pkg.sv
rtl/reg_file.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/hazard_control.sv
rtl/mips_pipe_top.sv
sim/tb_mem_model.sv
sim/tb_mips_pipe.sv
